//--- logic/axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

    //////////////////////
    // Bus and field widths
    localparam int addr_width = 32;
    localparam int data_width = 128;
    localparam int id_width = 16;
    localparam int len_width = 8;

    localparam int image_width_bits = 12;
    localparam int image_height_bits = 11;
    localparam int dram_addr_width = 39;

    //////////////////////
    // Write windows
    localparam logic [addr_width-1:0] win_fifo = 32'h0000_0000;
    localparam logic [addr_width-1:0] win_flush = 32'h0000_0010;
    localparam logic [addr_width-1:0] win_size = 32'h0000_0020;
    localparam logic [addr_width-1:0] win_buffer = 32'h0000_0030;

    // Only one readable window
    localparam logic [addr_width-1:0] rd_win_dram = 32'h0000_0000;

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    //////////////////////
    // Write channel states, drain swallows beats of an unmapped burst
    typedef enum logic [2:0] {
        idle,
        fifo,
        flush,
        size,
        buffer,
        drain,
        resp
    } write_state_t;

endpackage

`default_nettype wire

//--- logic/write_channel_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module write_channel_ctrl (
    input  logic                                 s_axi_aclk,
    input  logic                                 s_axi_aresetn,
    input  logic [axi_bridge_pkg::addr_width-1:0] s_axi_awaddr,
    input  logic [axi_bridge_pkg::id_width-1:0]   s_axi_awid,
    input  logic                                 s_axi_awvalid,
    output logic                                 s_axi_awready,
    input  logic                                 s_axi_wvalid,
    input  logic                                 s_axi_wlast,
    output logic                                 s_axi_wready,
    input  logic                                 fifo_wready,
    input  logic                                 buffer_wready,
    output logic                                 fifo_sel,
    output logic                                 buffer_sel,
    output logic                                 cfg_flush,
    output logic                                 cfg_size,
    input  logic                                 s_axi_bready,
    output logic                                 s_axi_bvalid,
    output logic [1:0]                           s_axi_bresp,
    output logic [axi_bridge_pkg::id_width-1:0]   s_axi_bid,
    input  logic                                 dram_read_en,
    output logic                                 dram_read_busy
);

    axi_bridge_pkg::write_state_t state;
    axi_bridge_pkg::write_state_t aw_target;
    logic aw_accept;
    logic w_accept;
    logic w_final;

    //////////////////////
    // Window decode

    always_comb begin
        case (s_axi_awaddr)
            axi_bridge_pkg::win_fifo:   aw_target = axi_bridge_pkg::fifo;
            axi_bridge_pkg::win_flush:  aw_target = axi_bridge_pkg::flush;
            axi_bridge_pkg::win_size:   aw_target = axi_bridge_pkg::size;
            axi_bridge_pkg::win_buffer: aw_target = axi_bridge_pkg::buffer;
            default:                    aw_target = axi_bridge_pkg::drain;
        endcase
    end

    assign s_axi_awready = (state == axi_bridge_pkg::idle);
    assign aw_accept = s_axi_awvalid & s_axi_awready;

    // Sink windows follow their forwarder, the rest always take data
    always_comb begin
        case (state)
            axi_bridge_pkg::fifo:   s_axi_wready = fifo_wready;
            axi_bridge_pkg::buffer: s_axi_wready = buffer_wready;
            axi_bridge_pkg::flush,
            axi_bridge_pkg::size,
            axi_bridge_pkg::drain:  s_axi_wready = 1'b1;
            default:                s_axi_wready = 1'b0;
        endcase
    end

    assign w_accept = s_axi_wvalid & s_axi_wready;
    assign w_final = w_accept & s_axi_wlast;

    assign fifo_sel = (state == axi_bridge_pkg::fifo);
    assign buffer_sel = (state == axi_bridge_pkg::buffer);
    assign cfg_flush = (state == axi_bridge_pkg::flush);
    assign cfg_size = (state == axi_bridge_pkg::size);
    assign s_axi_bvalid = (state == axi_bridge_pkg::resp);

    //////////////////////
    // Burst sequencing

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= axi_bridge_pkg::idle;
        end else begin
            case (state)
                axi_bridge_pkg::idle: begin
                    if (aw_accept) begin
                        state <= aw_target;
                    end
                end
                axi_bridge_pkg::resp: begin
                    if (s_axi_bready) begin
                        state <= axi_bridge_pkg::idle;
                    end
                end
                default: begin
                    if (w_final) begin
                        state <= axi_bridge_pkg::resp;
                    end
                end
            endcase
        end
    end

    // Response fields are fixed at the address phase
    always_ff @(posedge s_axi_aclk) begin
        if (aw_accept) begin
            s_axi_bid <= s_axi_awid;
            s_axi_bresp <= (aw_target == axi_bridge_pkg::drain) ?
                axi_bridge_pkg::resp_slverr : axi_bridge_pkg::resp_okay;
        end
    end

    //////////////////////
    // DRAM read busy

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            dram_read_busy <= 1'b0;
        end else if (buffer_sel && w_final) begin
            dram_read_busy <= 1'b0;
        end else if (state == axi_bridge_pkg::idle && dram_read_en) begin
            dram_read_busy <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/beat_forwarder.sv
`timescale 1ns/1ns
`default_nettype none

module beat_forwarder (
    input  logic                                 s_axi_aclk,
    input  logic                                 s_axi_aresetn,
    input  logic                                 sel,
    input  logic                                 s_axi_wvalid,
    input  logic [axi_bridge_pkg::data_width-1:0] s_axi_wdata,
    input  logic                                 sink_full,
    output logic                                 wready,
    output logic [axi_bridge_pkg::data_width-1:0] sink_data,
    output logic                                 sink_write
);

    logic accept;

    // Hold off the master while the sink is full
    assign wready = sel & ~sink_full;
    assign accept = wready & s_axi_wvalid;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            sink_write <= 1'b0;
        end else begin
            sink_write <= accept;
        end
    end

    // Data only moves on an accepted beat
    always_ff @(posedge s_axi_aclk) begin
        if (accept) begin
            sink_data <= s_axi_wdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/image_config_regs.sv
`timescale 1ns/1ns
`default_nettype none

module image_config_regs (
    input  logic                                        s_axi_aclk,
    input  logic                                        s_axi_aresetn,
    input  logic                                        cfg_flush,
    input  logic                                        cfg_size,
    input  logic                                        s_axi_wvalid,
    input  logic [axi_bridge_pkg::data_width-1:0]        s_axi_wdata,
    output logic                                        image_sender_flush,
    output logic [axi_bridge_pkg::image_width_bits-1:0]  image_width,
    output logic [axi_bridge_pkg::image_height_bits-1:0] image_height
);

    //////////////////////
    // Flush request

    // One pulse per beat with bit 0 set
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            image_sender_flush <= 1'b0;
        end else begin
            image_sender_flush <= cfg_flush & s_axi_wvalid & s_axi_wdata[0];
        end
    end

    //////////////////////
    // Image size

    // Width sits in the upper word, height in the lower
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            image_width <= '0;
            image_height <= '0;
        end else if (cfg_size && s_axi_wvalid) begin
            image_width <= s_axi_wdata[32 +: axi_bridge_pkg::image_width_bits];
            image_height <= s_axi_wdata[0 +: axi_bridge_pkg::image_height_bits];
        end
    end

endmodule

`default_nettype wire

//--- logic/read_responder.sv
`timescale 1ns/1ns
`default_nettype none

module read_responder (
    input  logic                                      s_axi_aclk,
    input  logic                                      s_axi_aresetn,
    input  logic [axi_bridge_pkg::addr_width-1:0]      s_axi_araddr,
    input  logic [axi_bridge_pkg::id_width-1:0]        s_axi_arid,
    input  logic [axi_bridge_pkg::len_width-1:0]       s_axi_arlen,
    input  logic                                      s_axi_arvalid,
    output logic                                      s_axi_arready,
    input  logic                                      s_axi_rready,
    output logic [axi_bridge_pkg::data_width-1:0]      s_axi_rdata,
    output logic [axi_bridge_pkg::id_width-1:0]        s_axi_rid,
    output logic [1:0]                                s_axi_rresp,
    output logic                                      s_axi_rvalid,
    output logic                                      s_axi_rlast,
    input  logic [axi_bridge_pkg::dram_addr_width-1:0] dram_read_addr,
    input  logic [axi_bridge_pkg::len_width-1:0]       dram_read_len
);

    typedef enum logic {
        rd_idle,
        rd_send
    } read_state_t;

    read_state_t state;
    logic [axi_bridge_pkg::len_width-1:0] beats_left;
    logic [axi_bridge_pkg::data_width-1:0] dram_beat;
    logic ar_accept;
    logic r_accept;

    // Length in the upper half, address in the lower
    assign dram_beat = {64'(dram_read_len), 64'(dram_read_addr)};

    assign s_axi_arready = (state == rd_idle);
    assign ar_accept = s_axi_arvalid & s_axi_arready;
    assign r_accept = s_axi_rvalid & s_axi_rready;

    //////////////////////
    // Control

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= rd_idle;
            s_axi_rvalid <= 1'b0;
            s_axi_rlast <= 1'b0;
        end else if (ar_accept) begin
            state <= rd_send;
            s_axi_rvalid <= 1'b1;
            // Error beat is always a single last beat
            s_axi_rlast <= (s_axi_araddr != axi_bridge_pkg::rd_win_dram) ||
                (s_axi_arlen == '0);
        end else if (r_accept) begin
            if (s_axi_rlast) begin
                state <= rd_idle;
                s_axi_rvalid <= 1'b0;
                s_axi_rlast <= 1'b0;
            end else begin
                s_axi_rlast <= (beats_left == 8'd1);
            end
        end
    end

    //////////////////////
    // Beat payload, steady while rready is low

    always_ff @(posedge s_axi_aclk) begin
        if (ar_accept) begin
            s_axi_rid <= s_axi_arid;
            beats_left <= s_axi_arlen;
            if (s_axi_araddr == axi_bridge_pkg::rd_win_dram) begin
                s_axi_rdata <= dram_beat;
                s_axi_rresp <= axi_bridge_pkg::resp_okay;
            end else begin
                s_axi_rdata <= '0;
                s_axi_rresp <= axi_bridge_pkg::resp_slverr;
            end
        end else if (r_accept && !s_axi_rlast) begin
            beats_left <= beats_left - 1'b1;
            s_axi_rdata <= dram_beat;
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_image_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module axi_image_bridge (
    input  logic                                        s_axi_aclk,
    input  logic                                        s_axi_aresetn,
    input  logic [axi_bridge_pkg::addr_width-1:0]        s_axi_awaddr,
    input  logic [axi_bridge_pkg::id_width-1:0]          s_axi_awid,
    input  logic                                        s_axi_awvalid,
    output logic                                        s_axi_awready,
    input  logic [axi_bridge_pkg::data_width-1:0]        s_axi_wdata,
    input  logic                                        s_axi_wvalid,
    input  logic                                        s_axi_wlast,
    output logic                                        s_axi_wready,
    input  logic                                        s_axi_bready,
    output logic                                        s_axi_bvalid,
    output logic [1:0]                                  s_axi_bresp,
    output logic [axi_bridge_pkg::id_width-1:0]          s_axi_bid,
    input  logic [axi_bridge_pkg::addr_width-1:0]        s_axi_araddr,
    input  logic [axi_bridge_pkg::id_width-1:0]          s_axi_arid,
    input  logic [axi_bridge_pkg::len_width-1:0]         s_axi_arlen,
    input  logic                                        s_axi_arvalid,
    output logic                                        s_axi_arready,
    input  logic                                        s_axi_rready,
    output logic [axi_bridge_pkg::data_width-1:0]        s_axi_rdata,
    output logic [axi_bridge_pkg::id_width-1:0]          s_axi_rid,
    output logic [1:0]                                  s_axi_rresp,
    output logic                                        s_axi_rvalid,
    output logic                                        s_axi_rlast,
    output logic                                        image_sender_reset,
    output logic                                        image_sender_write,
    output logic                                        image_sender_flush,
    output logic [axi_bridge_pkg::data_width-1:0]        image_sender_fifo_din,
    input  logic                                        image_sender_full,
    output logic [axi_bridge_pkg::image_width_bits-1:0]  image_width,
    output logic [axi_bridge_pkg::image_height_bits-1:0] image_height,
    input  logic                                        dram_buffer_full,
    input  logic                                        dram_read_en,
    output logic [axi_bridge_pkg::data_width-1:0]        dram_read_data,
    output logic                                        dram_read_data_valid,
    output logic                                        dram_read_busy,
    input  logic [axi_bridge_pkg::dram_addr_width-1:0]   dram_read_addr,
    input  logic [axi_bridge_pkg::len_width-1:0]         dram_read_len
);

    logic fifo_sel;
    logic buffer_sel;
    logic fifo_wready;
    logic buffer_wready;
    logic cfg_flush;
    logic cfg_size;

    assign image_sender_reset = ~s_axi_aresetn;

    //////////////////////
    // Write path

    write_channel_ctrl i_write_channel_ctrl (
        .s_axi_aclk     (s_axi_aclk),
        .s_axi_aresetn  (s_axi_aresetn),
        .s_axi_awaddr   (s_axi_awaddr),
        .s_axi_awid     (s_axi_awid),
        .s_axi_awvalid  (s_axi_awvalid),
        .s_axi_awready  (s_axi_awready),
        .s_axi_wvalid   (s_axi_wvalid),
        .s_axi_wlast    (s_axi_wlast),
        .s_axi_wready   (s_axi_wready),
        .fifo_wready    (fifo_wready),
        .buffer_wready  (buffer_wready),
        .fifo_sel       (fifo_sel),
        .buffer_sel     (buffer_sel),
        .cfg_flush      (cfg_flush),
        .cfg_size       (cfg_size),
        .s_axi_bready   (s_axi_bready),
        .s_axi_bvalid   (s_axi_bvalid),
        .s_axi_bresp    (s_axi_bresp),
        .s_axi_bid      (s_axi_bid),
        .dram_read_en   (dram_read_en),
        .dram_read_busy (dram_read_busy)
    );

    // Image sender FIFO
    beat_forwarder i_fifo_forwarder (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .sel           (fifo_sel),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wdata   (s_axi_wdata),
        .sink_full     (image_sender_full),
        .wready        (fifo_wready),
        .sink_data     (image_sender_fifo_din),
        .sink_write    (image_sender_write)
    );

    // DRAM staging buffer
    beat_forwarder i_buffer_forwarder (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .sel           (buffer_sel),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wdata   (s_axi_wdata),
        .sink_full     (dram_buffer_full),
        .wready        (buffer_wready),
        .sink_data     (dram_read_data),
        .sink_write    (dram_read_data_valid)
    );

    image_config_regs i_image_config_regs (
        .s_axi_aclk         (s_axi_aclk),
        .s_axi_aresetn      (s_axi_aresetn),
        .cfg_flush          (cfg_flush),
        .cfg_size           (cfg_size),
        .s_axi_wvalid       (s_axi_wvalid),
        .s_axi_wdata        (s_axi_wdata),
        .image_sender_flush (image_sender_flush),
        .image_width        (image_width),
        .image_height       (image_height)
    );

    //////////////////////
    // Read path

    read_responder i_read_responder (
        .s_axi_aclk     (s_axi_aclk),
        .s_axi_aresetn  (s_axi_aresetn),
        .s_axi_araddr   (s_axi_araddr),
        .s_axi_arid     (s_axi_arid),
        .s_axi_arlen    (s_axi_arlen),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rready   (s_axi_rready),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rid      (s_axi_rid),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rlast    (s_axi_rlast),
        .dram_read_addr (dram_read_addr),
        .dram_read_len  (dram_read_len)
    );

endmodule

`default_nettype wire

//--- sim/tb_axi_image_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_image_bridge;

    // Six short tests need well under a thousand cycles
    localparam int timeout_cycles = 4000;

    logic                                        s_axi_aclk = 1'b0;
    logic                                        s_axi_aresetn;
    logic [axi_bridge_pkg::addr_width-1:0]        s_axi_awaddr;
    logic [axi_bridge_pkg::id_width-1:0]          s_axi_awid;
    logic                                        s_axi_awvalid;
    logic                                        s_axi_awready;
    logic [axi_bridge_pkg::data_width-1:0]        s_axi_wdata;
    logic                                        s_axi_wvalid;
    logic                                        s_axi_wlast;
    logic                                        s_axi_wready;
    logic                                        s_axi_bready;
    logic                                        s_axi_bvalid;
    logic [1:0]                                  s_axi_bresp;
    logic [axi_bridge_pkg::id_width-1:0]          s_axi_bid;
    logic [axi_bridge_pkg::addr_width-1:0]        s_axi_araddr;
    logic [axi_bridge_pkg::id_width-1:0]          s_axi_arid;
    logic [axi_bridge_pkg::len_width-1:0]         s_axi_arlen;
    logic                                        s_axi_arvalid;
    logic                                        s_axi_arready;
    logic                                        s_axi_rready = 1'b1;
    logic [axi_bridge_pkg::data_width-1:0]        s_axi_rdata;
    logic [axi_bridge_pkg::id_width-1:0]          s_axi_rid;
    logic [1:0]                                  s_axi_rresp;
    logic                                        s_axi_rvalid;
    logic                                        s_axi_rlast;
    logic                                        image_sender_reset;
    logic                                        image_sender_write;
    logic                                        image_sender_flush;
    logic [axi_bridge_pkg::data_width-1:0]        image_sender_fifo_din;
    logic                                        image_sender_full = 1'b0;
    logic [axi_bridge_pkg::image_width_bits-1:0]  image_width;
    logic [axi_bridge_pkg::image_height_bits-1:0] image_height;
    logic                                        dram_buffer_full = 1'b0;
    logic                                        dram_read_en;
    logic [axi_bridge_pkg::data_width-1:0]        dram_read_data;
    logic                                        dram_read_data_valid;
    logic                                        dram_read_busy;
    logic [axi_bridge_pkg::dram_addr_width-1:0]   dram_read_addr;
    logic [axi_bridge_pkg::len_width-1:0]         dram_read_len;

    integer seed = 32'h1450a062;
    logic [31:0] stall_bits;
    logic fifo_stall_on = 1'b0;
    logic buffer_stall_on = 1'b0;
    logic rready_stall_on = 1'b0;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int flush_count = 0;

    logic [127:0] wr_beats [$];
    logic [127:0] fifo_seen [$];
    logic [127:0] buf_seen [$];
    logic [127:0] rd_data [$];
    logic [1:0] rd_resp [$];
    logic [15:0] rd_id [$];
    logic rd_last [$];

    axi_image_bridge i_axi_image_bridge (.*);

    always #4 s_axi_aclk = ~s_axi_aclk;

    //////////////////////
    // Background stalls and sink capture

    always @(negedge s_axi_aclk) begin
        stall_bits = $random(seed);
        image_sender_full = fifo_stall_on & stall_bits[0];
        dram_buffer_full = buffer_stall_on & stall_bits[1];
        s_axi_rready = ~(rready_stall_on & stall_bits[2]);
    end

    // Write pulses are registered, so one negedge sees each pulse once
    always @(negedge s_axi_aclk) begin
        if (image_sender_write) begin
            fifo_seen.push_back(image_sender_fifo_din);
        end
        if (dram_read_data_valid) begin
            buf_seen.push_back(dram_read_data);
        end
        if (image_sender_flush) begin
            flush_count++;
        end
    end

    // A full sink must hold off the write channel
    always @(posedge s_axi_aclk) begin
        if (image_sender_full || dram_buffer_full) begin
            check_value(128'(s_axi_wvalid & s_axi_wready), 128'd0,
                        "beat taken while sink full");
        end
    end

    always @(posedge s_axi_aclk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////
    // Bus tasks

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // Sends the beats in wr_beats as one burst and returns the B response
    task automatic axi_write_burst(input logic [31:0] addr, input logic [15:0] id,
                                   output logic [1:0] resp, output logic [15:0] bid);
        @(negedge s_axi_aclk);
        s_axi_awaddr = addr;
        s_axi_awid = id;
        s_axi_awvalid = 1'b1;
        do @(posedge s_axi_aclk); while (!s_axi_awready);
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        foreach (wr_beats[i]) begin
            s_axi_wdata = wr_beats[i];
            s_axi_wlast = (i == wr_beats.size() - 1);
            s_axi_wvalid = 1'b1;
            do @(posedge s_axi_aclk); while (!s_axi_wready);
            @(negedge s_axi_aclk);
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast = 1'b0;
        s_axi_bready = 1'b1;
        do @(posedge s_axi_aclk); while (!s_axi_bvalid);
        resp = s_axi_bresp;
        bid = s_axi_bid;
        @(negedge s_axi_aclk);
        s_axi_bready = 1'b0;
    endtask

    // Collects every R beat up to and including rlast
    task automatic axi_read_burst(input logic [31:0] addr, input logic [15:0] id,
                                  input logic [7:0] len);
        logic done;
        done = 1'b0;
        rd_data.delete();
        rd_resp.delete();
        rd_id.delete();
        rd_last.delete();
        @(negedge s_axi_aclk);
        s_axi_araddr = addr;
        s_axi_arid = id;
        s_axi_arlen = len;
        s_axi_arvalid = 1'b1;
        do @(posedge s_axi_aclk); while (!s_axi_arready);
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        while (!done) begin
            @(posedge s_axi_aclk);
            if (s_axi_rvalid && s_axi_rready) begin
                rd_data.push_back(s_axi_rdata);
                rd_resp.push_back(s_axi_rresp);
                rd_id.push_back(s_axi_rid);
                rd_last.push_back(s_axi_rlast);
                done = s_axi_rlast;
            end
        end
        @(negedge s_axi_aclk);
    endtask

    task automatic fill_beats(input int count);
        wr_beats.delete();
        repeat (count) begin
            wr_beats.push_back({$random(seed), $random(seed), $random(seed), $random(seed)});
        end
    endtask

    task automatic check_sink_beats(input logic [127:0] seen [$], input string sink);
        check_value(128'(seen.size()), 128'(wr_beats.size()), {sink, " beat count"});
        if (seen.size() == wr_beats.size()) begin
            foreach (seen[i]) begin
                check_value(seen[i], wr_beats[i], $sformatf("%s beat %0d", sink, i));
            end
        end
    endtask

    //////////////////////
    // Directed tests

    task automatic send_fifo_burst();
        logic [1:0] resp;
        logic [15:0] bid;
        fill_beats(5);
        fifo_seen.delete();
        fifo_stall_on = 1'b1;
        axi_write_burst(axi_bridge_pkg::win_fifo, 16'h1a2b, resp, bid);
        fifo_stall_on = 1'b0;
        check_sink_beats(fifo_seen, "fifo");
        check_value(128'(resp), 128'(axi_bridge_pkg::resp_okay), "fifo bresp");
        check_value(128'(bid), 128'h1a2b, "fifo bid");
    endtask

    // Width from bits 43:32, height from bits 10:0, junk elsewhere
    task automatic load_image_size();
        logic [1:0] resp;
        logic [15:0] bid;
        wr_beats.delete();
        wr_beats.push_back(128'hffff_ffff_0000_0fff_a5a5_f780_5a5a_fc38);
        axi_write_burst(axi_bridge_pkg::win_size, 16'h0020, resp, bid);
        check_value(128'(resp), 128'(axi_bridge_pkg::resp_okay), "size bresp");
        check_value(128'(image_width), 128'h780, "image width");
        check_value(128'(image_height), 128'h438, "image height");
    endtask

    task automatic request_flush();
        logic [1:0] resp;
        logic [15:0] bid;
        int start;
        start = flush_count;
        wr_beats.delete();
        wr_beats.push_back(128'h1);
        axi_write_burst(axi_bridge_pkg::win_flush, 16'h0010, resp, bid);
        check_value(128'(flush_count - start), 128'd1, "flush pulses for bit 0 set");
        check_value(128'(resp), 128'(axi_bridge_pkg::resp_okay), "flush bresp");
        start = flush_count;
        wr_beats.delete();
        wr_beats.push_back(128'hffff_0000_0000_0000_0000_0000_0000_fffe);
        axi_write_burst(axi_bridge_pkg::win_flush, 16'h0011, resp, bid);
        check_value(128'(flush_count - start), 128'd0, "flush pulses for bit 0 clear");
    endtask

    task automatic stage_dram_buffer();
        logic [1:0] resp;
        logic [15:0] bid;
        @(negedge s_axi_aclk);
        dram_read_en = 1'b1;
        @(negedge s_axi_aclk);
        dram_read_en = 1'b0;
        check_value(128'(dram_read_busy), 128'd1, "busy after read enable");
        fill_beats(4);
        buf_seen.delete();
        buffer_stall_on = 1'b1;
        axi_write_burst(axi_bridge_pkg::win_buffer, 16'h0030, resp, bid);
        buffer_stall_on = 1'b0;
        check_sink_beats(buf_seen, "buffer");
        check_value(128'(resp), 128'(axi_bridge_pkg::resp_okay), "buffer bresp");
        check_value(128'(dram_read_busy), 128'd0, "busy after buffer burst");
    endtask

    // Length lands in bits 71:64, address in bits 38:0
    task automatic read_dram_request();
        logic [127:0] expected_beat;
        dram_read_addr = 39'h51_2345_6789;
        dram_read_len = 8'h2c;
        expected_beat = {56'd0, dram_read_len, 25'd0, dram_read_addr};
        rready_stall_on = 1'b1;
        axi_read_burst(axi_bridge_pkg::rd_win_dram, 16'h0a11, 8'd2);
        rready_stall_on = 1'b0;
        check_value(128'(rd_data.size()), 128'd3, "dram read beat count");
        foreach (rd_data[i]) begin
            check_value(rd_data[i], expected_beat, $sformatf("dram read data %0d", i));
            check_value(128'(rd_resp[i]), 128'(axi_bridge_pkg::resp_okay), "dram rresp");
            check_value(128'(rd_id[i]), 128'h0a11, "dram rid");
            check_value(128'(rd_last[i]), 128'(i == 2), $sformatf("dram rlast %0d", i));
        end
    endtask

    task automatic hit_unmapped_windows();
        logic [1:0] resp;
        logic [15:0] bid;
        int start;
        fill_beats(2);
        fifo_seen.delete();
        buf_seen.delete();
        start = flush_count;
        axi_write_burst(32'h0000_0040, 16'h0040, resp, bid);
        check_value(128'(resp), 128'(axi_bridge_pkg::resp_slverr), "unmapped bresp");
        check_value(128'(bid), 128'h0040, "unmapped bid");
        check_value(128'(fifo_seen.size() + buf_seen.size()), 128'd0, "unmapped sink beats");
        check_value(128'(flush_count - start), 128'd0, "unmapped flush pulses");
        axi_read_burst(32'h0000_0008, 16'h0b22, 8'd3);
        check_value(128'(rd_data.size()), 128'd1, "error read beat count");
        foreach (rd_data[i]) begin
            check_value(rd_data[i], 128'd0, "error read data");
            check_value(128'(rd_resp[i]), 128'(axi_bridge_pkg::resp_slverr), "error rresp");
            check_value(128'(rd_id[i]), 128'h0b22, "error rid");
            check_value(128'(rd_last[i]), 128'd1, "error rlast");
        end
    endtask

    initial begin
        s_axi_aresetn = 1'b0;
        s_axi_awaddr = '0;
        s_axi_awid = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wvalid = 1'b0;
        s_axi_wlast = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arid = '0;
        s_axi_arlen = '0;
        s_axi_arvalid = 1'b0;
        dram_read_en = 1'b0;
        dram_read_addr = '0;
        dram_read_len = '0;
        repeat (3) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        check_value(128'(image_sender_reset), 128'd1, "sender reset during reset");
        s_axi_aresetn = 1'b1;
        check_value(128'(s_axi_bvalid), 128'd0, "bvalid after reset");
        check_value(128'(s_axi_rvalid), 128'd0, "rvalid after reset");
        check_value(128'(dram_read_busy), 128'd0, "busy after reset");
        @(posedge s_axi_aclk);
        check_value(128'(image_sender_reset), 128'd0, "sender reset after reset");

        send_fifo_burst();
        load_image_size();
        request_flush();
        stage_dram_buffer();
        read_dram_request();
        hit_unmapped_windows();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
logic/axi_bridge_pkg.sv
logic/write_channel_ctrl.sv
logic/beat_forwarder.sv
logic/image_config_regs.sv
logic/read_responder.sv
logic/axi_image_bridge.sv
sim/tb_axi_image_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_axi_image_bridge -f project.f \
    --Mdir obj_dir -o tb_axi_image_bridge \
    && ./obj_dir/tb_axi_image_bridge > "$log" 2>&1 \
    || { cat "$log" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$log"

grep -q "Checks failed" "$log" \
    && { echo "Result: FAIL"; exit 1; } \
    || { echo "Result: PASS"; exit 0; }
